// File: rtl/tcb_pkg.sv
// tcb shared constants, address map and decoded region type
package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus constants
  ////////////////////////////////////////////////////////////

  // byte width, byte enables cover this many data bits each
  localparam int unsigned TCB_SW = 8;
  // fixed response delay in cycles
  localparam int unsigned TCB_DLY = 1;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // region bases, both aligned to the span
  localparam logic [31:0] MEM_BASE = 32'h0000_0000;
  localparam logic [31:0] GPIO_BASE = 32'h0000_1000;
  // region size in bytes, power of two
  localparam logic [31:0] REGION_SPAN = 32'h0000_1000;

  // gpio register offsets inside its region
  localparam logic [31:0] GPIO_OUT_OFS = 32'h0000_0000;
  localparam logic [31:0] GPIO_IN_OFS = 32'h0000_0004;

  // decoded target of a request
  typedef enum logic [1:0] {
    REGION_MEM,
    REGION_GPIO,
    REGION_NONE
  } tcb_region_t;

endpackage : tcb_pkg

// File: rtl/tcb_arb.sv
// tcb fixed-priority arbiter, grant held while the owner keeps its lock
`timescale 1ns/1ps

module tcb_arb #(
  // number of managers
  parameter int unsigned PN = 2,
  localparam int unsigned PL = (PN > 1) ? $clog2(PN) : 1
)(
  input  logic          man,
  input  logic          arst_n,
  // request valid per manager
  input  logic          vld [PN-1:0],
  // arbitration lock per manager
  input  logic          lck [PN-1:0],
  // transfer strobe from the mux
  input  logic          trn,
  // grant index
  output logic [PL-1:0] sel
);

  // lowest requesting index
  logic [PL-1:0] pri;
  // lock owner state
  logic          own_lck;
  logic [PL-1:0] own_idx;

  ////////////////////////////////////////////////////////////
  // priority
  ////////////////////////////////////////////////////////////

  // scan from the top so the lowest index wins last
  always_comb begin
    pri = '0;
    for (int i = PN-1; i >= 0; i--) begin
      if (vld[i]) begin
        pri = PL'(i);
      end
    end
  end

  // owner keeps the grant while locked
  assign sel = own_lck ? own_idx : pri;

  ////////////////////////////////////////////////////////////
  // lock owner
  ////////////////////////////////////////////////////////////

  // captured on each transfer
  // a transfer without lock releases the owner
  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      own_lck <= 1'b0;
      own_idx <= '0;
    end else if (trn) begin
      own_lck <= lck[sel];
      own_idx <= sel;
    end
  end

endmodule : tcb_arb

// File: rtl/tcb_mux.sv
// tcb multiplexer from several managers to one path, registered response select
`timescale 1ns/1ps

module tcb_mux import tcb_pkg::*; #(
  // bus widths
  parameter int unsigned AW = 32,
  parameter int unsigned DW = 32,
  parameter int unsigned BW = DW/TCB_SW,
  // number of managers
  parameter int unsigned PN = 2,
  localparam int unsigned PL = (PN > 1) ? $clog2(PN) : 1
)(
  input  logic          man,
  input  logic          arst_n,
  // grant from the arbiter
  input  logic [PL-1:0] sel,
  // manager side request
  input  logic          sub_vld [PN-1:0],
  input  logic          sub_wen [PN-1:0],
  input  logic [AW-1:0] sub_adr [PN-1:0],
  input  logic [BW-1:0] sub_ben [PN-1:0],
  input  logic [DW-1:0] sub_wdt [PN-1:0],
  // manager side response
  output logic          sub_rdy [PN-1:0],
  output logic [DW-1:0] sub_rdt [PN-1:0],
  output logic          sub_err [PN-1:0],
  // shared request path
  output logic          dev_vld,
  output logic          dev_wen,
  output logic [AW-1:0] dev_adr,
  output logic [BW-1:0] dev_ben,
  output logic [DW-1:0] dev_wdt,
  // shared response path
  input  logic          dev_rdy,
  input  logic [DW-1:0] dev_rdt,
  input  logic          dev_err,
  // transfer strobe
  output logic          trn
);

  // owner of the response in flight
  logic [PL-1:0] rsp_sel;

  ////////////////////////////////////////////////////////////
  // request
  ////////////////////////////////////////////////////////////

  // granted manager drives the shared path
  assign dev_vld = sub_vld[sel];
  assign dev_wen = sub_wen[sel];
  assign dev_adr = sub_adr[sel];
  assign dev_ben = sub_ben[sel];
  assign dev_wdt = sub_wdt[sel];

  assign trn = dev_vld & dev_rdy;

  // response returns TCB_DLY cycles after the transfer,
  // so one stage of select history is enough
  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      rsp_sel <= '0;
    end else if (trn) begin
      rsp_sel <= sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : gen_rsp
    // ready only to the granted manager, request phase
    assign sub_rdy[i] = (sel == PL'(i)) ? dev_rdy : 1'b0;
    // data and error to the owner, response phase
    assign sub_rdt[i] = (rsp_sel == PL'(i)) ? dev_rdt : '0;
    assign sub_err[i] = (rsp_sel == PL'(i)) ? dev_err : 1'b0;
  end : gen_rsp

endmodule : tcb_mux

// File: rtl/tcb_demux.sv
// tcb address decoder and demultiplexer with error responder for unmapped space
`timescale 1ns/1ps

module tcb_demux import tcb_pkg::*; #(
  // bus widths
  parameter int unsigned AW = 32,
  parameter int unsigned DW = 32,
  parameter int unsigned BW = DW/TCB_SW
)(
  input  logic          man,
  input  logic          arst_n,
  // upstream request
  input  logic          dev_vld,
  input  logic          dev_wen,
  input  logic [AW-1:0] dev_adr,
  input  logic [BW-1:0] dev_ben,
  input  logic [DW-1:0] dev_wdt,
  // upstream response
  output logic          dev_rdy,
  output logic [DW-1:0] dev_rdt,
  output logic          dev_err,
  // memory subordinate
  output logic          mem_vld,
  output logic          mem_wen,
  output logic [AW-1:0] mem_adr,
  output logic [BW-1:0] mem_ben,
  output logic [DW-1:0] mem_wdt,
  input  logic          mem_rdy,
  input  logic [DW-1:0] mem_rdt,
  input  logic          mem_err,
  // gpio subordinate
  output logic          gpio_vld,
  output logic          gpio_wen,
  output logic [AW-1:0] gpio_adr,
  output logic [BW-1:0] gpio_ben,
  output logic [DW-1:0] gpio_wdt,
  input  logic          gpio_rdy,
  input  logic [DW-1:0] gpio_rdt,
  input  logic          gpio_err
);

  // region base mask, span is a power of two
  localparam logic [AW-1:0] BASE_MSK = ~(AW'(REGION_SPAN) - AW'(1));

  // decoded target now and for the response in flight
  tcb_region_t req_reg;
  tcb_region_t rsp_reg;

  ////////////////////////////////////////////////////////////
  // decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    if ((dev_adr & BASE_MSK) == AW'(MEM_BASE)) begin
      req_reg = REGION_MEM;
    end else if ((dev_adr & BASE_MSK) == AW'(GPIO_BASE)) begin
      req_reg = REGION_GPIO;
    end else begin
      req_reg = REGION_NONE;
    end
  end

  // valid only to the matching target
  assign mem_vld  = dev_vld & (req_reg == REGION_MEM);
  assign gpio_vld = dev_vld & (req_reg == REGION_GPIO);

  // payload shared by both targets
  assign mem_wen  = dev_wen;
  assign mem_adr  = dev_adr;
  assign mem_ben  = dev_ben;
  assign mem_wdt  = dev_wdt;
  assign gpio_wen = dev_wen;
  assign gpio_adr = dev_adr;
  assign gpio_ben = dev_ben;
  assign gpio_wdt = dev_wdt;

  // unmapped space always accepts
  always_comb begin
    case (req_reg)
      REGION_MEM:  dev_rdy = mem_rdy;
      REGION_GPIO: dev_rdy = gpio_rdy;
      default:     dev_rdy = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      rsp_reg <= REGION_MEM;
    end else if (dev_vld & dev_rdy) begin
      rsp_reg <= req_reg;
    end
  end

  // error response for unmapped space
  always_comb begin
    case (rsp_reg)
      REGION_MEM: begin
        dev_rdt = mem_rdt;
        dev_err = mem_err;
      end
      REGION_GPIO: begin
        dev_rdt = gpio_rdt;
        dev_err = gpio_err;
      end
      default: begin
        dev_rdt = '0;
        dev_err = 1'b1;
      end
    endcase
  end

endmodule : tcb_demux

// File: rtl/tcb_mem.sv
// tcb word memory subordinate with byte enables and registered read
`timescale 1ns/1ps

module tcb_mem import tcb_pkg::*; #(
  // bus widths
  parameter int unsigned AW = 32,
  parameter int unsigned DW = 32,
  parameter int unsigned BW = DW/TCB_SW,
  // number of words
  parameter int unsigned MEM_DEPTH = 256
)(
  input  logic          man,
  input  logic          arst_n,
  // request
  input  logic          vld,
  input  logic          wen,
  input  logic [AW-1:0] adr,
  input  logic [BW-1:0] ben,
  input  logic [DW-1:0] wdt,
  // response
  output logic          rdy,
  output logic [DW-1:0] rdt,
  output logic          err
);

  // byte offset and word index widths
  localparam int unsigned OW = (BW > 1) ? $clog2(BW) : 0;
  localparam int unsigned IW = $clog2(MEM_DEPTH);

  logic [DW-1:0] mem [MEM_DEPTH];
  logic [IW-1:0] idx;
  // read data register and its qualifier
  logic [DW-1:0] rdt_q;
  logic          rd_q;

  // word index above the byte offset
  assign idx = adr[OW +: IW];

  // never stalls, never fails
  assign rdy = 1'b1;
  assign err = 1'b0;

  ////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////

  always_ff @(posedge man) begin
    if (vld & wen) begin
      // only enabled bytes change
      for (int b = 0; b < BW; b++) begin
        if (ben[b]) begin
          mem[idx][b*TCB_SW +: TCB_SW] <= wdt[b*TCB_SW +: TCB_SW];
        end
      end
    end
    if (vld & ~wen) begin
      rdt_q <= mem[idx];
    end
  end

  // marks a read response for the next cycle
  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= vld & ~wen;
    end
  end

  // zero after writes
  assign rdt = rd_q ? rdt_q : '0;

endmodule : tcb_mem

// File: rtl/tcb_gpio.sv
// tcb gpio subordinate with output register and synchronized input register
`timescale 1ns/1ps

module tcb_gpio import tcb_pkg::*; #(
  // bus widths
  parameter int unsigned AW = 32,
  parameter int unsigned DW = 32,
  parameter int unsigned BW = DW/TCB_SW,
  // gpio width, at most DW
  parameter int unsigned GPIO_W = 8
)(
  input  logic              man,
  input  logic              arst_n,
  // request
  input  logic              vld,
  input  logic              wen,
  input  logic [AW-1:0]     adr,
  input  logic [BW-1:0]     ben,
  input  logic [DW-1:0]     wdt,
  // response
  output logic              rdy,
  output logic [DW-1:0]     rdt,
  output logic              err,
  // pins
  output logic [GPIO_W-1:0] gpio_out,
  input  logic [GPIO_W-1:0] gpio_in
);

  logic [AW-1:0]     ofs;
  logic              hit_out;
  logic              hit_in;
  // output register with byte enables applied
  logic [DW-1:0]     out_nxt;
  // two stage input sampling
  logic [GPIO_W-1:0] in_meta;
  logic [GPIO_W-1:0] in_sync;

  // offset inside the gpio region
  assign ofs = adr & (AW'(REGION_SPAN) - AW'(1));
  assign hit_out = (ofs == AW'(GPIO_OUT_OFS));
  assign hit_in  = (ofs == AW'(GPIO_IN_OFS));

  assign rdy = 1'b1;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_comb begin
    out_nxt = DW'(gpio_out);
    for (int b = 0; b < BW; b++) begin
      if (ben[b]) begin
        out_nxt[b*TCB_SW +: TCB_SW] = wdt[b*TCB_SW +: TCB_SW];
      end
    end
  end

  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out <= '0;
      in_meta  <= '0;
      in_sync  <= '0;
      err      <= 1'b0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
      if (vld & wen & hit_out) begin
        gpio_out <= out_nxt[GPIO_W-1:0];
      end
      // input register is read only
      if (vld) begin
        err <= ~(hit_out | (hit_in & ~wen));
      end
    end
  end

  // read data, zero for writes and errors
  always_ff @(posedge man) begin
    if (vld) begin
      if (~wen & hit_out) begin
        rdt <= DW'(gpio_out);
      end else if (~wen & hit_in) begin
        rdt <= DW'(in_sync);
      end else begin
        rdt <= '0;
      end
    end
  end

endmodule : tcb_gpio

// File: rtl/tcb_top.sv
// tcb interconnect top joining arbiter, mux, demux, memory and gpio
`timescale 1ns/1ps

module tcb_top import tcb_pkg::*; #(
  parameter int unsigned AW = 32,
  parameter int unsigned DW = 32,
  parameter int unsigned PN = 2,
  parameter int unsigned MEM_DEPTH = 256,
  parameter int unsigned GPIO_W = 8,
  localparam int unsigned BW = DW/TCB_SW,
  localparam int unsigned PL = (PN > 1) ? $clog2(PN) : 1
)(
  input  logic              man,
  input  logic              arst_n,
  // manager ports
  input  logic              man_vld [PN-1:0],
  input  logic              man_wen [PN-1:0],
  input  logic [AW-1:0]     man_adr [PN-1:0],
  input  logic [BW-1:0]     man_ben [PN-1:0],
  input  logic [DW-1:0]     man_wdt [PN-1:0],
  input  logic              man_lck [PN-1:0],
  output logic              man_rdy [PN-1:0],
  output logic [DW-1:0]     man_rdt [PN-1:0],
  output logic              man_err [PN-1:0],
  // pins
  output logic [GPIO_W-1:0] gpio_out,
  input  logic [GPIO_W-1:0] gpio_in
);

  // arbitration
  logic [PL-1:0] sel;
  logic          trn;
  // shared path behind the mux
  logic          dev_vld, dev_wen, dev_rdy, dev_err;
  logic [AW-1:0] dev_adr;
  logic [BW-1:0] dev_ben;
  logic [DW-1:0] dev_wdt, dev_rdt;
  // memory path
  logic          mem_vld, mem_wen, mem_rdy, mem_err;
  logic [AW-1:0] mem_adr;
  logic [BW-1:0] mem_ben;
  logic [DW-1:0] mem_wdt, mem_rdt;
  // gpio path
  logic          gpio_vld, gpio_wen, gpio_rdy, gpio_err;
  logic [AW-1:0] gpio_adr;
  logic [BW-1:0] gpio_ben;
  logic [DW-1:0] gpio_wdt, gpio_rdt;

  tcb_arb #(.PN(PN)) arb_i (
    .man(man), .arst_n(arst_n), .vld(man_vld), .lck(man_lck), .trn(trn), .sel(sel)
  );

  tcb_mux #(.AW(AW), .DW(DW), .BW(BW), .PN(PN)) mux_i (
    .man(man), .arst_n(arst_n), .sel(sel),
    .sub_vld(man_vld), .sub_wen(man_wen), .sub_adr(man_adr),
    .sub_ben(man_ben), .sub_wdt(man_wdt),
    .sub_rdy(man_rdy), .sub_rdt(man_rdt), .sub_err(man_err),
    .dev_vld(dev_vld), .dev_wen(dev_wen), .dev_adr(dev_adr),
    .dev_ben(dev_ben), .dev_wdt(dev_wdt),
    .dev_rdy(dev_rdy), .dev_rdt(dev_rdt), .dev_err(dev_err), .trn(trn)
  );

  tcb_demux #(.AW(AW), .DW(DW), .BW(BW)) demux_i (
    .man(man), .arst_n(arst_n),
    .dev_vld(dev_vld), .dev_wen(dev_wen), .dev_adr(dev_adr),
    .dev_ben(dev_ben), .dev_wdt(dev_wdt),
    .dev_rdy(dev_rdy), .dev_rdt(dev_rdt), .dev_err(dev_err),
    .mem_vld(mem_vld), .mem_wen(mem_wen), .mem_adr(mem_adr),
    .mem_ben(mem_ben), .mem_wdt(mem_wdt),
    .mem_rdy(mem_rdy), .mem_rdt(mem_rdt), .mem_err(mem_err),
    .gpio_vld(gpio_vld), .gpio_wen(gpio_wen), .gpio_adr(gpio_adr),
    .gpio_ben(gpio_ben), .gpio_wdt(gpio_wdt),
    .gpio_rdy(gpio_rdy), .gpio_rdt(gpio_rdt), .gpio_err(gpio_err)
  );

  tcb_mem #(.AW(AW), .DW(DW), .BW(BW), .MEM_DEPTH(MEM_DEPTH)) mem_i (
    .man(man), .arst_n(arst_n),
    .vld(mem_vld), .wen(mem_wen), .adr(mem_adr), .ben(mem_ben), .wdt(mem_wdt),
    .rdy(mem_rdy), .rdt(mem_rdt), .err(mem_err)
  );

  tcb_gpio #(.AW(AW), .DW(DW), .BW(BW), .GPIO_W(GPIO_W)) gpio_i (
    .man(man), .arst_n(arst_n),
    .vld(gpio_vld), .wen(gpio_wen), .adr(gpio_adr), .ben(gpio_ben), .wdt(gpio_wdt),
    .rdy(gpio_rdy), .rdt(gpio_rdt), .err(gpio_err),
    .gpio_out(gpio_out), .gpio_in(gpio_in)
  );

endmodule : tcb_top

// File: tb/tcb_top_asserts.sv
// tcb mux protocol assertions bound into the multiplexer
`timescale 1ns/1ps

module tcb_mux_asserts import tcb_pkg::*; #(
  parameter int unsigned AW = 32,
  parameter int unsigned DW = 32,
  parameter int unsigned PN = 2
)(
  input  logic          man,
  input  logic          arst_n,
  // manager side request
  input  logic          sub_vld [PN-1:0],
  input  logic          sub_wen [PN-1:0],
  input  logic [AW-1:0] sub_adr [PN-1:0],
  input  logic          sub_rdy [PN-1:0],
  // manager side response
  input  logic [DW-1:0] sub_rdt [PN-1:0],
  input  logic          sub_err [PN-1:0],
  // shared response path
  input  logic [DW-1:0] dev_rdt,
  input  logic          dev_err
);

  // assertion failures so far
  int unsigned fail_cnt;

  initial fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : gen_mgr

    // a waiting request holds until its transfer
    req_hold: assert property (@(posedge man) disable iff (!arst_n)
      sub_vld[i] && !sub_rdy[i] |=>
        sub_vld[i] && $stable(sub_wen[i]) && $stable(sub_adr[i]))
      else begin
        $error("manager %0d changed its request before the transfer", i);
        fail_cnt++;
      end

    // response goes back to the manager that made the transfer
    rsp_own: assert property (@(posedge man) disable iff (!arst_n)
      sub_vld[i] && sub_rdy[i] |-> ##TCB_DLY
        (sub_rdt[i] === dev_rdt) && (sub_err[i] === dev_err))
      else begin
        $error("response of manager %0d was not routed back to it", i);
        fail_cnt++;
      end

  end : gen_mgr

endmodule : tcb_mux_asserts

bind tcb_mux tcb_mux_asserts #(.AW(AW), .DW(DW), .PN(PN)) mux_asserts_i (
  .man(man), .arst_n(arst_n),
  .sub_vld(sub_vld), .sub_wen(sub_wen), .sub_adr(sub_adr), .sub_rdy(sub_rdy),
  .sub_rdt(sub_rdt), .sub_err(sub_err), .dev_rdt(dev_rdt), .dev_err(dev_err)
);

// File: tb/tcb_top_tb.sv
// directed testbench for the tcb interconnect, memory, gpio and error paths
`timescale 1ns/1ps

module tcb_top_tb import tcb_pkg::*; ();

  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;
  localparam int unsigned BW = DW/TCB_SW;
  localparam int unsigned PN = 2;
  localparam int unsigned MEM_DEPTH = 256;
  localparam int unsigned GPIO_W = 8;
  localparam int unsigned OW = $clog2(BW);
  localparam int unsigned IW = $clog2(MEM_DEPTH);
  // cycles before a wait gives up
  localparam int TMO = 50;

  logic              man;
  logic              arst_n;
  logic              man_vld [PN-1:0];
  logic              man_wen [PN-1:0];
  logic [AW-1:0]     man_adr [PN-1:0];
  logic [BW-1:0]     man_ben [PN-1:0];
  logic [DW-1:0]     man_wdt [PN-1:0];
  logic              man_lck [PN-1:0];
  logic              man_rdy [PN-1:0];
  logic [DW-1:0]     man_rdt [PN-1:0];
  logic              man_err [PN-1:0];
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_in;

  // expected memory contents
  logic [DW-1:0] model [MEM_DEPTH];
  logic [31:0]   lfsr;
  int unsigned   cyc;
  int unsigned   data_errs;
  int unsigned   err_errs;
  int unsigned   tmo_errs;
  int unsigned   seq_errs;
  int unsigned   asrt_errs;

  tcb_top #(
    .AW(AW), .DW(DW), .PN(PN), .MEM_DEPTH(MEM_DEPTH), .GPIO_W(GPIO_W)
  ) tcb_top_i (
    .man(man), .arst_n(arst_n),
    .man_vld(man_vld), .man_wen(man_wen), .man_adr(man_adr), .man_ben(man_ben),
    .man_wdt(man_wdt), .man_lck(man_lck),
    .man_rdy(man_rdy), .man_rdt(man_rdt), .man_err(man_err),
    .gpio_out(gpio_out), .gpio_in(gpio_in)
  );

  always #4 man = ~man;

  // cycle count for transfer ordering
  always @(posedge man) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // only enabled bytes of the model word change
  function automatic void model_write(input logic [AW-1:0] adr, input logic [BW-1:0] ben,
                                      input logic [DW-1:0] wdt);
    for (int b = 0; b < BW; b++) begin
      if (ben[b]) begin
        model[adr[OW +: IW]][b*TCB_SW +: TCB_SW] = wdt[b*TCB_SW +: TCB_SW];
      end
    end
  endfunction

  task automatic check_data(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      data_errs++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_errs++;
      $display("[ERROR] %s: expected err %b, actual err %b", name, exp, act);
    end
  endtask

  // one request from manager idx, response sampled a cycle after the transfer
  task automatic bus_access(
    input  int            idx,
    input  logic          wen,
    input  logic [AW-1:0] adr,
    input  logic [BW-1:0] ben,
    input  logic [DW-1:0] wdt,
    input  logic          lck,
    output logic [DW-1:0] rdt,
    output logic          err,
    output int unsigned   tcyc
  );
    int t;
    @(posedge man);
    man_vld[idx] <= 1'b1;
    man_wen[idx] <= wen;
    man_adr[idx] <= adr;
    man_ben[idx] <= ben;
    man_wdt[idx] <= wdt;
    man_lck[idx] <= lck;
    // wait for the grant
    t = 0;
    @(negedge man);
    while (!man_rdy[idx] && t < TMO) begin
      @(negedge man);
      t++;
    end
    if (!man_rdy[idx]) begin
      tmo_errs++;
      $display("timeout: manager %0d never got ready for address %h", idx, adr);
    end
    tcyc = cyc;
    // transfer edge
    @(posedge man);
    man_vld[idx] <= 1'b0;
    man_lck[idx] <= 1'b0;
    @(negedge man);
    rdt = man_rdt[idx];
    err = man_err[idx];
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic mem_test;
    logic [AW-1:0] adr;
    logic [BW-1:0] ben;
    logic [DW-1:0] wdt;
    logic [DW-1:0] rdt;
    logic          err;
    int unsigned   tc;
    for (int i = 0; i < 16; i++) begin
      adr = MEM_BASE + AW'(4*i);
      // full word first, then a partial overwrite
      wdt = rand_bits(DW);
      bus_access(0, 1'b1, adr, '1, wdt, 1'b0, rdt, err, tc);
      model_write(adr, '1, wdt);
      check_err("mem_write", 1'b0, err);
      wdt = rand_bits(DW);
      ben = BW'(rand_bits(BW));
      bus_access(0, 1'b1, adr, ben, wdt, 1'b0, rdt, err, tc);
      model_write(adr, ben, wdt);
      bus_access(0, 1'b0, adr, '0, '0, 1'b0, rdt, err, tc);
      check_data("mem_readback", model[adr[OW +: IW]], rdt);
      check_err("mem_readback", 1'b0, err);
    end
  endtask

  task automatic prio_test;
    logic [DW-1:0] rdt0;
    logic [DW-1:0] rdt1;
    logic          err0;
    logic          err1;
    int unsigned   tc0;
    int unsigned   tc1;
    fork
      bus_access(0, 1'b0, MEM_BASE + 32'h0C, '0, '0, 1'b0, rdt0, err0, tc0);
      bus_access(1, 1'b0, MEM_BASE + 32'h24, '0, '0, 1'b0, rdt1, err1, tc1);
    join
    if (tc1 <= tc0) begin
      seq_errs++;
      $display("priority: manager 1 transferred in cycle %0d, manager 0 only in %0d", tc1, tc0);
    end
    check_data("prio_m0", model[3], rdt0);
    check_data("prio_m1", model[9], rdt1);
    check_err("prio_m0", 1'b0, err0);
    check_err("prio_m1", 1'b0, err1);
  endtask

  task automatic lock_test;
    logic [DW-1:0] wdt;
    logic [DW-1:0] rdt0;
    logic [DW-1:0] rdt1;
    logic          err0;
    logic          err1;
    int unsigned   tc0;
    int unsigned   tc1;
    wdt = rand_bits(DW);
    fork
      begin
        // locked write and read, then an unlocked read releases
        bus_access(1, 1'b1, MEM_BASE + 32'h10, '1, wdt, 1'b1, rdt1, err1, tc1);
        model_write(MEM_BASE + 32'h10, '1, wdt);
        check_err("lock_write", 1'b0, err1);
        bus_access(1, 1'b0, MEM_BASE + 32'h10, '0, '0, 1'b1, rdt1, err1, tc1);
        check_data("lock_read1", model[4], rdt1);
        bus_access(1, 1'b0, MEM_BASE + 32'h14, '0, '0, 1'b0, rdt1, err1, tc1);
        check_data("lock_read2", model[5], rdt1);
      end
      begin
        // arrives after the lock is taken
        repeat (2) @(posedge man);
        bus_access(0, 1'b0, MEM_BASE + 32'h10, '0, '0, 1'b0, rdt0, err0, tc0);
      end
    join
    if (tc0 <= tc1) begin
      seq_errs++;
      $display("lock: manager 0 transferred in cycle %0d inside the locked run", tc0);
    end
    check_data("lock_waiter", model[4], rdt0);
    check_err("lock_waiter", 1'b0, err0);
  endtask

  task automatic pipeline_test;
    @(posedge man);
    for (int k = 0; k <= 8; k++) begin
      if (k < 8) begin
        man_vld[0] <= 1'b1;
        man_wen[0] <= 1'b0;
        man_adr[0] <= MEM_BASE + AW'(4*k);
        man_ben[0] <= '0;
      end else begin
        man_vld[0] <= 1'b0;
      end
      @(negedge man);
      // response of the previous transfer
      if (k > 0) begin
        check_data("pipeline", model[k-1], man_rdt[0]);
        check_err("pipeline", 1'b0, man_err[0]);
      end
      if (k < 8) begin
        if (!man_rdy[0]) begin
          seq_errs++;
          $display("pipeline: no ready for read %0d, a transfer cycle was lost", k);
        end
        @(posedge man);
      end
    end
  endtask

  task automatic gpio_test;
    logic [DW-1:0]     wdt;
    logic [DW-1:0]     rdt;
    logic              err;
    logic [GPIO_W-1:0] pin;
    int unsigned       tc;
    int                t;
    wdt = rand_bits(DW);
    bus_access(0, 1'b1, GPIO_BASE + GPIO_OUT_OFS, 4'b0001, wdt, 1'b0, rdt, err, tc);
    check_err("gpio_out_write", 1'b0, err);
    check_data("gpio_out_pin", DW'(wdt[GPIO_W-1:0]), DW'(gpio_out));
    bus_access(0, 1'b0, GPIO_BASE + GPIO_OUT_OFS, '0, '0, 1'b0, rdt, err, tc);
    check_data("gpio_out_read", DW'(wdt[GPIO_W-1:0]), rdt);
    // nonzero so the poll must see the change
    pin = GPIO_W'(rand_bits(GPIO_W)) | GPIO_W'(1);
    @(posedge man);
    gpio_in <= pin;
    t = 0;
    rdt = '0;
    while (rdt !== DW'(pin) && t < TMO) begin
      bus_access(0, 1'b0, GPIO_BASE + GPIO_IN_OFS, '0, '0, 1'b0, rdt, err, tc);
      t++;
    end
    if (rdt !== DW'(pin)) begin
      tmo_errs++;
      $display("timeout: gpio_in value %h never showed in the input register", pin);
    end
    check_err("gpio_in_read", 1'b0, err);
    // input register is read only
    bus_access(0, 1'b1, GPIO_BASE + GPIO_IN_OFS, '1, wdt, 1'b0, rdt, err, tc);
    check_err("gpio_in_write", 1'b1, err);
    check_data("gpio_in_write", '0, rdt);
  endtask

  task automatic unmapped_test;
    logic [DW-1:0] rdt;
    logic          err;
    int unsigned   tc;
    bus_access(0, 1'b0, 32'h0000_2000, '0, '0, 1'b0, rdt, err, tc);
    check_err("unmapped_read", 1'b1, err);
    check_data("unmapped_read", '0, rdt);
    bus_access(1, 1'b1, 32'h0000_2000, '1, 32'hDEAD_BEEF, 1'b0, rdt, err, tc);
    check_err("unmapped_write", 1'b1, err);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    man = 1'b0;
    arst_n = 1'b0;
    cyc = 0;
    lfsr = 32'd97010;
    data_errs = 0;
    err_errs = 0;
    tmo_errs = 0;
    seq_errs = 0;
    for (int i = 0; i < PN; i++) begin
      man_vld[i] = 1'b0;
      man_wen[i] = 1'b0;
      man_adr[i] = '0;
      man_ben[i] = '0;
      man_wdt[i] = '0;
      man_lck[i] = 1'b0;
    end
    gpio_in = '0;
    repeat (10) @(posedge man);
    arst_n <= 1'b1;
    mem_test();
    prio_test();
    lock_test();
    pipeline_test();
    gpio_test();
    unmapped_test();
    repeat (2) @(posedge man);
    asrt_errs = tcb_top_i.mux_i.mux_asserts_i.fail_cnt;
    $display("errors: data %0d, err %0d, timeout %0d, order %0d, assertion %0d",
             data_errs, err_errs, tmo_errs, seq_errs, asrt_errs);
    if (data_errs + err_errs + tmo_errs + seq_errs + asrt_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tcb_top_tb

// File: project.f
rtl/tcb_pkg.sv
rtl/tcb_arb.sv
rtl/tcb_mux.sv
rtl/tcb_demux.sv
rtl/tcb_mem.sv
rtl/tcb_gpio.sv
rtl/tcb_top.sv
tb/tcb_top_asserts.sv
tb/tcb_top_tb.sv
